// File: verilog/conv_row_pkg.sv
`default_nettype none

package conv_row_pkg;

  //////////////////////////////////////////////////
  // geometry defaults
  //////////////////////////////////////////////////

  // pixels per buffer row as a power of two
  localparam int pixels_in_row_in_2pow = 5;
  // input features packed per buffer word
  localparam int ifs_in_row_2pow = 1;
  // input row buffer depth in words
  localparam int input_buffer_size_2pow = 12;
  // slab buffer depth in words
  localparam int slab_buffer_size_2pow = 13;

  // row or address outside the padded input
  localparam logic [15:0] invalid_row = 16'hffff;

  //////////////////////////////////////////////////
  // layer and request types
  //////////////////////////////////////////////////

  // layer configuration, latched once per tile
  typedef struct packed {
    logic [3:0]  s;
    logic [3:0]  p;
    logic [15:0] iy;
    logic [3:0]  nif_in_2pow;
    logic [3:0]  ix_in_2pow;
    logic [15:0] poy;
  } layer_cfg_t;

  // one address request from the walker
  typedef struct packed {
    logic [15:0] iy_start;
    logic [15:0] ky;
    logic [15:0] row_base_in_3s;
    logic [15:0] row_start_idx;
    logic [15:0] if_start;
    logic [15:0] row_slab_start_idx;
    logic [3:0]  slab_num;
  } row_req_t;

  // translated row and buffer locations
  typedef struct packed {
    logic [15:0] row_idx;
    logic [15:0] buf_adr;
    logic [1:0]  buf_idx;
    logic        word_select;
    logic [15:0] slab_adr;
    logic [1:0]  slab_idx;
    logic [15:0] slab_adr_to_wr;
    logic [1:0]  slab_idx_to_wr;
  } row_adr_t;

  // walker states
  typedef enum logic [1:0] {
    idle  = 2'd0,
    walk  = 2'd1,
    drain = 2'd2
  } walk_state_e;

endpackage

`default_nettype wire

// File: verilog/row_walk_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module row_walk_ctrl (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     start,
  input  wire conv_row_pkg::layer_cfg_t cfg,
  input  wire logic [15:0]              tile_iy_start,
  input  wire logic [15:0]              tile_row_base_in_3s,
  input  wire logic [15:0]              tile_row_start_idx,
  input  wire logic [15:0]              tile_row_slab_start_idx,
  input  wire logic [3:0]               tile_slab_num,
  output logic                          cfg_load,
  output conv_row_pkg::row_req_t        req,
  output logic                          req_valid,
  output logic                          busy,
  output logic                          done
);

  conv_row_pkg::walk_state_e state;
  conv_row_pkg::row_req_t    tile_q;

  // ky is the outer loop, feature word the inner one
  logic [1:0]  ky_cnt;
  logic [15:0] word_cnt;
  logic [15:0] word_last;
  logic [1:0]  drain_cnt;
  logic [3:0]  word_shift;

  // feature words per kernel row as a power of two
  assign word_shift = 4'(cfg.nif_in_2pow - conv_row_pkg::ifs_in_row_2pow);

  // translator latches cfg in the same cycle as start
  assign cfg_load  = start && (state == conv_row_pkg::idle);
  assign busy      = (state != conv_row_pkg::idle);
  assign req_valid = (state == conv_row_pkg::walk);

  //////////////////////////////////////////////////
  // request assembly
  //////////////////////////////////////////////////

  always_comb begin
    req          = tile_q;
    req.ky       = {14'd0, ky_cnt};
    // if_start walks 1, 3, 5 ... two features per word
    req.if_start = {word_cnt[14:0], 1'b1};
  end

  // tile descriptor and inner loop limit, held for the whole tile
  always_ff @(posedge clk) begin
    if (cfg_load) begin
      tile_q.iy_start           <= tile_iy_start;
      tile_q.ky                 <= '0;
      tile_q.row_base_in_3s     <= tile_row_base_in_3s;
      tile_q.row_start_idx      <= tile_row_start_idx;
      tile_q.if_start           <= '0;
      tile_q.row_slab_start_idx <= tile_row_slab_start_idx;
      tile_q.slab_num           <= tile_slab_num;
      word_last                 <= (16'd1 << word_shift) - 16'd1;
    end
  end

  //////////////////////////////////////////////////
  // walk FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= conv_row_pkg::idle;
      ky_cnt    <= '0;
      word_cnt  <= '0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        conv_row_pkg::idle: begin
          if (start) begin
            ky_cnt   <= '0;
            word_cnt <= '0;
            state    <= conv_row_pkg::walk;
          end
        end
        conv_row_pkg::walk: begin
          if (word_cnt == word_last) begin
            word_cnt <= '0;
            // last word of ky = 2 ends the walk
            if (ky_cnt == 2'd2) begin
              drain_cnt <= '0;
              state     <= conv_row_pkg::drain;
            end else begin
              ky_cnt <= ky_cnt + 2'd1;
            end
          end else begin
            word_cnt <= word_cnt + 16'd1;
          end
        end
        conv_row_pkg::drain: begin
          // four cycles cover translator and buffer read latency
          drain_cnt <= drain_cnt + 2'd1;
          if (drain_cnt == 2'd3) begin
            done  <= 1'b1;
            state <= conv_row_pkg::idle;
          end
        end
        default: state <= conv_row_pkg::idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/row3_adr_translate.sv
`timescale 1ns/1ps
`default_nettype none

module row3_adr_translate #(
  parameter int pixels_in_row_in_2pow  = conv_row_pkg::pixels_in_row_in_2pow,
  parameter int ifs_in_row_2pow        = conv_row_pkg::ifs_in_row_2pow,
  parameter int input_buffer_size_2pow = conv_row_pkg::input_buffer_size_2pow,
  parameter int slab_buffer_size_2pow  = conv_row_pkg::slab_buffer_size_2pow
) (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     cfg_load,
  input  wire conv_row_pkg::layer_cfg_t cfg,
  input  wire conv_row_pkg::row_req_t   req,
  input  wire logic                     req_valid,
  output conv_row_pkg::row_adr_t        adr,
  output logic                          adr_valid
);

  //////////////////////////////////////////////////
  // layer config and derived limits
  //////////////////////////////////////////////////

  conv_row_pkg::layer_cfg_t cfg_q;
  logic [5:0]  s_mult_3;
  logic [15:0] mask_in;
  logic [15:0] mask_slab;

  // rows that fit in each buffer as a power of two
  logic [4:0] in_rows_2pow;
  logic [4:0] slab_rows_2pow;

  assign in_rows_2pow = 5'(input_buffer_size_2pow - (cfg.nif_in_2pow - ifs_in_row_2pow
                        + cfg.ix_in_2pow - pixels_in_row_in_2pow));
  assign slab_rows_2pow = 5'(slab_buffer_size_2pow - (cfg.nif_in_2pow
                          + cfg.ix_in_2pow - pixels_in_row_in_2pow));

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg_q     <= '0;
      s_mult_3  <= '0;
      mask_in   <= '0;
      mask_slab <= '0;
    end else if (cfg_load) begin
      cfg_q     <= cfg;
      s_mult_3  <= {2'b00, cfg.s} + {1'b0, cfg.s, 1'b0};
      mask_in   <= 16'hffff >> (5'd16 - in_rows_2pow);
      mask_slab <= 16'hffff >> (5'd16 - slab_rows_2pow);
    end
  end

  //////////////////////////////////////////////////
  // stage 1: row index, row base and bias
  //////////////////////////////////////////////////

  logic [15:0] t_row;
  logic [15:0] p_ext;
  logic [15:0] base3;
  logic [15:0] bias0;
  logic        row_out;
  logic        wraps;

  // t = ky + iy_start + 2s
  assign t_row   = req.ky + req.iy_start + {11'd0, cfg_q.s, 1'b0};
  assign p_ext   = {12'd0, cfg_q.p};
  assign base3   = req.row_base_in_3s + (req.row_base_in_3s << 1);
  // only rows in p+1 .. p+iy hold input data
  assign row_out = (cfg_q.poy < 16'd3) || (t_row < p_ext + 16'd1)
                   || (t_row > p_ext + cfg_q.iy);
  // row sits below the current base so step back one triple
  assign wraps   = (t_row <= p_ext + base3);
  assign bias0   = t_row - p_ext - base3;

  conv_row_pkg::row_req_t s1_req;
  logic [15:0] s1_row_idx;
  logic [15:0] s1_row_base;
  logic [15:0] s1_bias;
  logic        s1_valid;

  always_ff @(posedge clk) begin
    s1_req      <= req;
    s1_row_idx  <= row_out ? conv_row_pkg::invalid_row : t_row - p_ext;
    s1_row_base <= wraps ? req.row_base_in_3s - 16'd1 : req.row_base_in_3s;
    s1_bias     <= wraps ? bias0 + {10'd0, s_mult_3} : bias0;
  end

  //////////////////////////////////////////////////
  // stage 2: fold bias into buffer index and offset
  //////////////////////////////////////////////////

  logic [15:0] fold_idx;
  logic [1:0]  fold_off;
  logic        s1_out;

  assign s1_out = (s1_row_idx == conv_row_pkg::invalid_row);

  // bias bands 1..3, 4..6, 7..9, 10..12
  always_comb begin
    if (s1_bias <= 16'd3) begin
      fold_idx = s1_bias;
      fold_off = 2'd0;
    end else if (s1_bias <= 16'd6) begin
      fold_idx = s1_bias - 16'd3;
      fold_off = 2'd1;
    end else if (s1_bias <= 16'd9) begin
      fold_idx = s1_bias - 16'd6;
      fold_off = 2'd2;
    end else begin
      fold_idx = s1_bias - 16'd9;
      fold_off = 2'd3;
    end
  end

  conv_row_pkg::row_req_t s2_req;
  logic [15:0] s2_row_idx;
  logic [15:0] s2_row_in_buf;
  logic [1:0]  s2_buf_idx;
  logic        s2_valid;

  always_ff @(posedge clk) begin
    s2_req        <= s1_req;
    s2_row_idx    <= s1_row_idx;
    s2_buf_idx    <= s1_out ? 2'd0 : fold_idx[1:0];
    s2_row_in_buf <= s1_out ? 16'd0 : s1_row_base + {14'd0, fold_off};
  end

  //////////////////////////////////////////////////
  // stage 3: masks and shifts into addresses
  //////////////////////////////////////////////////

  logic [3:0]  in_row_shift;
  logic [3:0]  in_word_shift;
  logic [3:0]  slab_row_shift;
  logic [15:0] if_m1;
  logic [15:0] slab_row_term;
  logic        s2_out;
  conv_row_pkg::row_adr_t adr_next;

  assign in_word_shift  = 4'(cfg_q.nif_in_2pow - ifs_in_row_2pow);
  assign in_row_shift   = 4'(cfg_q.nif_in_2pow - ifs_in_row_2pow + cfg_q.ix_in_2pow
                          - pixels_in_row_in_2pow);
  assign slab_row_shift = 4'(cfg_q.nif_in_2pow + cfg_q.ix_in_2pow - pixels_in_row_in_2pow);
  assign if_m1          = s2_req.if_start - 16'd1;
  assign slab_row_term  = (s2_row_in_buf & mask_slab) << slab_row_shift;
  assign s2_out         = (s2_row_idx == conv_row_pkg::invalid_row);

  always_comb begin
    adr_next.row_idx     = s2_row_idx;
    adr_next.buf_idx     = s2_buf_idx;
    adr_next.word_select = if_m1[0];
    adr_next.buf_adr     = s2_out ? conv_row_pkg::invalid_row :
                           ((s2_row_in_buf & mask_in) << in_row_shift)
                           + ((s2_req.row_start_idx << in_word_shift) >> pixels_in_row_in_2pow)
                           + (if_m1 >> ifs_in_row_2pow);
    // read side of the slab, absent when no slab is held
    adr_next.slab_adr    = (s2_req.slab_num == 4'd0) ? conv_row_pkg::invalid_row :
                           slab_row_term
                           + ((s2_req.row_slab_start_idx << cfg_q.nif_in_2pow)
                              >> pixels_in_row_in_2pow)
                           + if_m1;
    adr_next.slab_idx    = (s2_req.slab_num == 4'd0) ? 2'd0 : s2_buf_idx;
    // write back side follows the input row
    adr_next.slab_adr_to_wr = s2_out ? conv_row_pkg::invalid_row :
                              slab_row_term
                              + ((s2_req.row_start_idx << cfg_q.nif_in_2pow)
                                 >> pixels_in_row_in_2pow)
                              + if_m1;
    adr_next.slab_idx_to_wr = s2_buf_idx;
  end

  always_ff @(posedge clk) begin
    adr <= adr_next;
    if (reset) begin
      adr.buf_idx        <= '0;
      adr.slab_idx       <= '0;
      adr.slab_idx_to_wr <= '0;
    end
  end

  // valid follows the request through all three stages
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      adr_valid <= 1'b0;
    end else begin
      s1_valid  <= req_valid && (cfg_q.poy >= 16'd3);
      s2_valid  <= s1_valid;
      adr_valid <= s2_valid;
    end
  end

endmodule

`default_nettype wire

// File: verilog/input_row_buffers.sv
`timescale 1ns/1ps
`default_nettype none

module input_row_buffers #(
  parameter int input_buffer_size_2pow = conv_row_pkg::input_buffer_size_2pow
) (
  input  wire logic                   clk,
  input  wire logic                   reset,
  input  wire logic                   wr_en,
  input  wire logic [1:0]             wr_bank,
  input  wire logic [15:0]            wr_adr,
  input  wire logic [31:0]            wr_data,
  input  wire conv_row_pkg::row_adr_t adr,
  input  wire logic                   adr_valid,
  output logic [15:0]                 rd_data,
  output logic                        rd_valid
);

  localparam int depth = 1 << input_buffer_size_2pow;

  //////////////////////////////////////////////////
  // three rotating row banks numbered 1..3
  //////////////////////////////////////////////////

  for (genvar b = 0; b < 3; b++) begin : g_bank
    logic [31:0] mem [depth];
    logic [31:0] bank_word;

    always_ff @(posedge clk) begin
      if (wr_en && (wr_bank == 2'(b + 1))) begin
        mem[wr_adr[input_buffer_size_2pow-1:0]] <= wr_data;
      end
      if (adr_valid) begin
        bank_word <= mem[adr.buf_adr[input_buffer_size_2pow-1:0]];
      end
    end
  end

  // read side selects captured with the word
  logic [1:0] bank_q;
  logic       half_q;
  logic       zero_q;

  always_ff @(posedge clk) begin
    if (adr_valid) begin
      bank_q <= adr.buf_idx;
      half_q <= adr.word_select;
      zero_q <= (adr.row_idx == conv_row_pkg::invalid_row);
    end
  end

  logic [31:0] word_sel;

  // bank 0 does not exist and reads as zero
  always_comb begin
    case (bank_q)
      2'd1:    word_sel = g_bank[0].bank_word;
      2'd2:    word_sel = g_bank[1].bank_word;
      2'd3:    word_sel = g_bank[2].bank_word;
      default: word_sel = 32'd0;
    endcase
    // padding rows read as zero
    if (zero_q) begin
      rd_data = 16'd0;
    end else begin
      rd_data = half_q ? word_sel[31:16] : word_sel[15:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= adr_valid;
    end
  end

endmodule

`default_nettype wire

// File: verilog/conv_row_fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module conv_row_fetch_top #(
  parameter int pixels_in_row_in_2pow  = conv_row_pkg::pixels_in_row_in_2pow,
  parameter int ifs_in_row_2pow        = conv_row_pkg::ifs_in_row_2pow,
  parameter int input_buffer_size_2pow = conv_row_pkg::input_buffer_size_2pow,
  parameter int slab_buffer_size_2pow  = conv_row_pkg::slab_buffer_size_2pow
) (
  input  wire logic                     clk,
  input  wire logic                     reset,
  input  wire logic                     start,
  input  wire conv_row_pkg::layer_cfg_t cfg,
  input  wire logic [15:0]              iy_start,
  input  wire logic [15:0]              row_base_in_3s,
  input  wire logic [15:0]              row_start_idx,
  input  wire logic [15:0]              row_slab_start_idx,
  input  wire logic [3:0]               slab_num,
  input  wire logic                     buf_wr_en,
  input  wire logic [1:0]               buf_wr_bank,
  input  wire logic [15:0]              buf_wr_adr,
  input  wire logic [31:0]              buf_wr_data,
  output logic                          busy,
  output logic                          done,
  output conv_row_pkg::row_adr_t        adr,
  output logic                          adr_valid,
  output logic [15:0]                   rd_data,
  output logic                          rd_valid
);

  logic                   cfg_load;
  conv_row_pkg::row_req_t req;
  logic                   req_valid;

  // walker, one request per cycle over a tile
  row_walk_ctrl u_ctrl (
    .clk                     (clk),
    .reset                   (reset),
    .start                   (start),
    .cfg                     (cfg),
    .tile_iy_start           (iy_start),
    .tile_row_base_in_3s     (row_base_in_3s),
    .tile_row_start_idx      (row_start_idx),
    .tile_row_slab_start_idx (row_slab_start_idx),
    .tile_slab_num           (slab_num),
    .cfg_load                (cfg_load),
    .req                     (req),
    .req_valid               (req_valid),
    .busy                    (busy),
    .done                    (done)
  );

  // three cycle request to address pipeline
  row3_adr_translate #(
    .pixels_in_row_in_2pow  (pixels_in_row_in_2pow),
    .ifs_in_row_2pow        (ifs_in_row_2pow),
    .input_buffer_size_2pow (input_buffer_size_2pow),
    .slab_buffer_size_2pow  (slab_buffer_size_2pow)
  ) u_translate (
    .clk       (clk),
    .reset     (reset),
    .cfg_load  (cfg_load),
    .cfg       (cfg),
    .req       (req),
    .req_valid (req_valid),
    .adr       (adr),
    .adr_valid (adr_valid)
  );

  // pixel fetch at the translated location
  input_row_buffers #(
    .input_buffer_size_2pow (input_buffer_size_2pow)
  ) u_buffers (
    .clk       (clk),
    .reset     (reset),
    .wr_en     (buf_wr_en),
    .wr_bank   (buf_wr_bank),
    .wr_adr    (buf_wr_adr),
    .wr_data   (buf_wr_data),
    .adr       (adr),
    .adr_valid (adr_valid),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

endmodule

`default_nettype wire

// File: verif/conv_row_fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv_row_fetch_tb;

  localparam int max_tiles  = 8;
  // cycle bound on the wait for done
  localparam int done_limit = 200;

  logic                     clk;
  logic                     reset;
  logic                     start;
  conv_row_pkg::layer_cfg_t cfg;
  logic [15:0]              iy_start;
  logic [15:0]              row_base_in_3s;
  logic [15:0]              row_start_idx;
  logic [15:0]              row_slab_start_idx;
  logic [3:0]               slab_num;
  logic                     buf_wr_en;
  logic [1:0]               buf_wr_bank;
  logic [15:0]              buf_wr_adr;
  logic [31:0]              buf_wr_data;
  logic                     busy;
  logic                     done;
  conv_row_pkg::row_adr_t   adr;
  logic                     adr_valid;
  logic [15:0]              rd_data;
  logic                     rd_valid;

  conv_row_fetch_top DUT (
    .clk                (clk),
    .reset              (reset),
    .start              (start),
    .cfg                (cfg),
    .iy_start           (iy_start),
    .row_base_in_3s     (row_base_in_3s),
    .row_start_idx      (row_start_idx),
    .row_slab_start_idx (row_slab_start_idx),
    .slab_num           (slab_num),
    .buf_wr_en          (buf_wr_en),
    .buf_wr_bank        (buf_wr_bank),
    .buf_wr_adr         (buf_wr_adr),
    .buf_wr_data        (buf_wr_data),
    .busy               (busy),
    .done               (done),
    .adr                (adr),
    .adr_valid          (adr_valid),
    .rd_data            (rd_data),
    .rd_valid           (rd_valid)
  );

  always #5 clk = ~clk;

  // run bookkeeping
  int          errors;
  int          test_errors;
  int          tests;
  int          failed_tests;
  logic        timed_out;
  logic [31:0] lcg_state;

  //////////////////////////////////////////////////
  // parsed vectors
  //////////////////////////////////////////////////

  logic [1:0]               pl_bank [$];
  logic [15:0]              pl_adr [$];
  logic [31:0]              pl_data [$];
  conv_row_pkg::row_adr_t   exp_adr [$];
  logic [15:0]              exp_data [$];
  // tile descriptor rides in a request struct with ky and if_start left at zero
  logic [8*24-1:0]          tile_name [max_tiles];
  conv_row_pkg::layer_cfg_t tile_cfg [max_tiles];
  conv_row_pkg::row_req_t   tile_desc [max_tiles];
  int                       tile_first [max_tiles];
  int                       tile_count [max_tiles];
  int                       ntiles;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    lcg_next = x * 32'd1103515245 + 32'd12345;
  endfunction

  //////////////////////////////////////////////////
  // checks and reporting
  //////////////////////////////////////////////////

  task automatic compare_adr(input string name, input conv_row_pkg::row_adr_t exp,
                             input conv_row_pkg::row_adr_t act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic compare_data(input string name, input logic [15:0] exp,
                              input logic [15:0] act);
    if (act !== exp) begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("** Error %s: expected %0d, actual %0d", name, exp, act);
      errors++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      failed_tests++;
      $display("%s: %0d error(s)", name, test_errors);
    end
    test_errors = 0;
  endtask

  //////////////////////////////////////////////////
  // vector file parser
  //////////////////////////////////////////////////

  task automatic read_vectors();
    int                     fd;
    int                     code;
    int                     ch;
    int                     f [11];
    logic [7:0]             kind;
    logic [8*24-1:0]        name;
    conv_row_pkg::row_adr_t a;
    ntiles = 0;
    fd = $fopen("verif/conv_row_fetch_vectors.txt", "r");
    if (fd == 0) begin
      report_failure("cannot open verif/conv_row_fetch_vectors.txt");
      return;
    end
    // each record opens with a kind character
    code = $fscanf(fd, " %c", kind);
    while (code == 1) begin
      case (kind)
        "#": begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
          end
        end
        "P": begin
          code = $fscanf(fd, "%h %h %h", f[0], f[1], f[2]);
          pl_bank.push_back(2'(f[0]));
          pl_adr.push_back(16'(f[1]));
          pl_data.push_back(32'(f[2]));
        end
        "T": begin
          code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h", name, f[0], f[1],
                         f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
          tile_name[ntiles]                        = name;
          tile_cfg[ntiles].s                       = 4'(f[0]);
          tile_cfg[ntiles].p                       = 4'(f[1]);
          tile_cfg[ntiles].iy                      = 16'(f[2]);
          tile_cfg[ntiles].nif_in_2pow             = 4'(f[3]);
          tile_cfg[ntiles].ix_in_2pow              = 4'(f[4]);
          tile_cfg[ntiles].poy                     = 16'(f[5]);
          tile_desc[ntiles]                        = '0;
          tile_desc[ntiles].iy_start               = 16'(f[6]);
          tile_desc[ntiles].row_base_in_3s         = 16'(f[7]);
          tile_desc[ntiles].row_start_idx          = 16'(f[8]);
          tile_desc[ntiles].row_slab_start_idx     = 16'(f[9]);
          tile_desc[ntiles].slab_num               = 4'(f[10]);
          tile_first[ntiles]                       = exp_adr.size();
          tile_count[ntiles]                       = 0;
          ntiles++;
        end
        "E": begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
                         f[4], f[5], f[6], f[7], f[8]);
          a.row_idx        = 16'(f[0]);
          a.buf_adr        = 16'(f[1]);
          a.buf_idx        = 2'(f[2]);
          a.word_select    = 1'(f[3]);
          a.slab_adr       = 16'(f[4]);
          a.slab_idx       = 2'(f[5]);
          a.slab_adr_to_wr = 16'(f[6]);
          a.slab_idx_to_wr = 2'(f[7]);
          exp_adr.push_back(a);
          exp_data.push_back(16'(f[8]));
          if (ntiles > 0) begin
            tile_count[ntiles-1]++;
          end
        end
        default: report_failure("vectors file holds a record of unknown kind");
      endcase
      code = $fscanf(fd, " %c", kind);
    end
    $fclose(fd);
    if (ntiles == 0) begin
      report_failure("vectors file holds no tile records");
    end
  endtask

  //////////////////////////////////////////////////
  // one tile from start to done
  //////////////////////////////////////////////////

  task automatic run_tile(input int t);
    int    n_req;
    int    n_exp;
    int    adr_cnt;
    int    rd_cnt;
    int    cycles;
    int    first;
    int    busy_bad;
    logic  seen_done;
    string tname;
    tname     = $sformatf("%0s", tile_name[t]);
    // ky outer loop times the feature words of one row
    n_req     = 3 << (tile_cfg[t].nif_in_2pow - conv_row_pkg::ifs_in_row_2pow);
    n_exp     = (tile_cfg[t].poy < 16'd3) ? 0 : n_req;
    first     = tile_first[t];
    adr_cnt   = 0;
    rd_cnt    = 0;
    busy_bad  = 0;
    seen_done = 1'b0;
    compare_count({tname, " expected records"}, n_exp, tile_count[t]);
    @(negedge clk);
    cfg                = tile_cfg[t];
    iy_start           = tile_desc[t].iy_start;
    row_base_in_3s     = tile_desc[t].row_base_in_3s;
    row_start_idx      = tile_desc[t].row_start_idx;
    row_slab_start_idx = tile_desc[t].row_slab_start_idx;
    slab_num           = tile_desc[t].slab_num;
    start              = 1'b1;
    @(negedge clk);
    start  = 1'b0;
    cycles = 1;
    // sample outputs on falling edges, halfway between updates
    while (!seen_done && cycles <= done_limit) begin
      if (adr_valid === 1'b1) begin
        if (adr_cnt < tile_count[t]) begin
          compare_adr($sformatf("%s adr %0d", tname, adr_cnt), exp_adr[first+adr_cnt], adr);
        end
        adr_cnt++;
      end
      if (rd_valid === 1'b1) begin
        if (rd_cnt < tile_count[t]) begin
          compare_data($sformatf("%s data %0d", tname, rd_cnt), exp_data[first+rd_cnt],
                       rd_data);
        end
        rd_cnt++;
      end
      // busy holds from start up to the cycle where done pulses
      if (done !== 1'b1 && busy !== 1'b1) begin
        busy_bad++;
      end
      if (done === 1'b1 && busy !== 1'b0) begin
        busy_bad++;
      end
      if (done === 1'b1) begin
        seen_done = 1'b1;
      end else begin
        @(negedge clk);
        cycles++;
      end
    end
    if (!seen_done) begin
      report_failure($sformatf("%s: done did not arrive within %0d cycles of start",
                               tname, done_limit));
      timed_out = 1'b1;
    end else begin
      compare_count({tname, " done cycle"}, 1 + n_req + 4, cycles);
    end
    if (busy_bad > 0) begin
      report_failure($sformatf("%s: busy was wrong in %0d cycles of the tile",
                               tname, busy_bad));
    end
    compare_count({tname, " adr_valid pulses"}, n_exp, adr_cnt);
    compare_count({tname, " rd_valid pulses"}, n_exp, rd_cnt);
    finish_test(tname);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    int bad;
    int gap;
    clk                = 1'b0;
    reset              = 1'b1;
    start              = 1'b0;
    cfg                = '0;
    iy_start           = '0;
    row_base_in_3s     = '0;
    row_start_idx      = '0;
    row_slab_start_idx = '0;
    slab_num           = '0;
    buf_wr_en          = 1'b0;
    buf_wr_bank        = '0;
    buf_wr_adr         = '0;
    buf_wr_data        = '0;
    errors             = 0;
    test_errors        = 0;
    tests              = 0;
    failed_tests       = 0;
    timed_out          = 1'b0;
    lcg_state          = 32'hb83a;
    bad                = 0;
    read_vectors();
    repeat (8) @(negedge clk);
    reset = 1'b0;

    // idle outputs through a few empty cycles and the buffer preload
    repeat (4) begin
      @(negedge clk);
      if (busy !== 1'b0 || done !== 1'b0 || adr_valid !== 1'b0 || rd_valid !== 1'b0) begin
        bad++;
      end
    end
    for (int i = 0; i < pl_bank.size(); i++) begin
      @(negedge clk);
      if (busy !== 1'b0 || done !== 1'b0 || adr_valid !== 1'b0 || rd_valid !== 1'b0) begin
        bad++;
      end
      buf_wr_en   = 1'b1;
      buf_wr_bank = pl_bank[i];
      buf_wr_adr  = pl_adr[i];
      buf_wr_data = pl_data[i];
    end
    @(negedge clk);
    buf_wr_en = 1'b0;
    if (bad > 0) begin
      report_failure($sformatf("busy, done or a valid output was high in %0d idle cycles",
                               bad));
    end
    finish_test("idle_after_reset");

    for (int t = 0; t < ntiles && !timed_out; t++) begin
      // pseudo random idle gap between tiles
      lcg_state = lcg_next(lcg_state);
      gap       = 2 + int'(lcg_state[23:16]) % 5;
      repeat (gap) @(negedge clk);
      run_tile(t);
    end

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/conv_row_fetch_vectors.txt
# P bank adr word32 | T name s p iy nif_in_2pow ix_in_2pow poy iy_start row_base_in_3s row_start_idx row_slab_start_idx slab_num
# E row_idx buf_adr buf_idx word_select slab_adr slab_idx slab_adr_to_wr slab_idx_to_wr rd_data, values in hex
P 1 0000 f00d0a01
P 1 0004 c0de1104
P 1 0005 c0de1105
P 2 0004 beef2204
P 2 0005 beef2205
P 3 0004 cafe3304
P 3 0005 cafe3305
T tile_in_range 1 1 0010 2 5 0010 0003 0001 0020 0040 1
E 0004 0004 1 0 000c 1 0008 1 1104
E 0004 0005 1 0 000e 1 000a 1 1105
E 0005 0004 2 0 000c 2 0008 2 2204
E 0005 0005 2 0 000e 2 000a 2 2205
E 0006 0004 3 0 000c 3 0008 3 3304
E 0006 0005 3 0 000e 3 000a 3 3305
T tile_row_range 1 2 0001 1 5 0008 0000 0000 0000 0000 1
E ffff ffff 0 0 0000 0 ffff 0 0000
E 0001 0000 1 0 0000 1 0000 1 0a01
E ffff ffff 0 0 0000 0 ffff 0 0000
T tile_no_slab 2 0 000a 1 5 0004 0000 0002 0040 0010 0
E 0004 0004 1 0 ffff 0 0008 1 1104
E 0005 0004 2 0 ffff 0 0008 2 2204
E 0006 0004 3 0 ffff 0 0008 3 3304
T tile_short_out 1 0 0008 1 5 0002 0000 0000 0000 0000 1

// File: build.f
verilog/conv_row_pkg.sv
verilog/row_walk_ctrl.sv
verilog/row3_adr_translate.sv
verilog/input_row_buffers.sv
verilog/conv_row_fetch_top.sv
verif/conv_row_fetch_tb.sv
